// ==== sim.f ====
common/fetch_pkg.sv
src/instr_predecode.sv
fetch/icache.sv
fetch/fetch_control.sv
src/fetch_top.sv
sim/bus_memory.sv
sim/fetch_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the fetch testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert -j 0 --top-module fetch_tb -f sim.f -Mdir obj_dir -o fetch_sim \
	&& ./obj_dir/fetch_sim > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }
cat sim.log
grep -qx "test passed" sim.log && exit 0 || exit 1

// ==== sim/fetch_tb.sv ====
`timescale 1ns/1ps

module fetch_tb;

	localparam int program_size = 64;
	localparam logic [31:0] lfsr_seed = 32'hb56e_4944;
	localparam int test_count = 2000;
	localparam int timeout_cycles = test_count * 16;
	localparam int tag_mask = (1 << fetch_pkg::tag_width) - 1;

	logic i_clock = 1'b0;
	logic i_reset;
	logic i_stall;
	logic i_resolve_valid;
	logic [fetch_pkg::tag_width-1:0] i_resolve_tag;
	logic [31:0] i_pc_next;
	logic o_bus_request;
	logic [31:0] o_bus_address;
	logic i_bus_ready;
	logic [31:0] i_bus_rdata;
	logic o_valid;
	logic [fetch_pkg::tag_width-1:0] o_tag;
	logic [31:0] o_instruction;
	logic [31:0] o_pc;

	logic [1:0] bus_latency;
	logic [31:0] program_words [program_size];
	logic [31:0] lfsr_state = lfsr_seed;
	logic [2:0] resolve_delay;
	logic [31:0] resolved_pc;
	logic [31:0] last_word;
	logic [31:0] last_pc;
	logic [fetch_pkg::tag_width-1:0] last_tag;
	// bus state seen at the previous negedge
	logic prev_request = 1'b0;
	logic prev_ready = 1'b0;
	logic [31:0] prev_address = '0;
	int cycles = 0;
	int error_count = 0;
	int deliveries = 0;
	// a branch or jalr delivery stays open until resolves_sent catches up
	int waits_seen = 0;
	int resolves_sent = 0;

	fetch_top dut_i (.*);

	bus_memory memory_i (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_latency(bus_latency),
		.i_program(program_words),
		.i_bus_request(o_bus_request),
		.i_bus_address(o_bus_address),
		.o_bus_ready(i_bus_ready),
		.o_bus_rdata(i_bus_rdata)
	);

	// galois lfsr, one step per bit taken
	function automatic logic [31:0] take_bits(input int count);
		logic [31:0] bits;
		bits = '0;
		for (int k = 0; k < count; k++) begin
			bits = {bits[30:0], lfsr_state[0]};
			if (lfsr_state[0])
				lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
			else
				lfsr_state = lfsr_state >> 1;
		end
		return bits;
	endfunction

	// next pc by instruction class
	function automatic logic [31:0] expected_next_pc(input logic [31:0] word,
			input logic [31:0] pc, input logic [31:0] resolved);
		logic signed [20:0] jump;
		jump = {word[31], word[19:12], word[20], word[30:21], 1'b0};
		case (word[6:0])
			fetch_pkg::op_jal: return pc + 32'(jump);
			fetch_pkg::op_branch, fetch_pkg::op_jalr: return resolved;
			default: return pc + 32'd4;
		endcase
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] want);
		if (got !== want) begin
			$display("MISMATCH %s: got 0x%08h, expected 0x%08h", name, got, want);
			error_count = error_count + 1;
		end
	endtask

	initial begin
		forever #2 i_clock = ~i_clock;
	end

	initial begin
		logic [2:0] kind;
		logic [31:0] fields;
		logic [20:0] offset;
		logic [31:0] target_pc;
		logic prev_wait;
		int target;
		i_reset = 1'b1;
		i_stall = 1'b0;
		i_resolve_valid = 1'b0;
		i_resolve_tag = '0;
		i_pc_next = '0;
		bus_latency = 2'd0;
		resolved_pc = '0;
		resolve_delay = 3'd2;
		prev_wait = 1'b0;
		// alu words, short jals, branches and jalrs; last word jumps back to 0
		for (int i = 0; i < program_size; i++) begin
			kind = 3'(take_bits(3));
			fields = take_bits(25) << 7;
			target = -1;
			if (i == program_size - 1) begin
				target = 0;
			end else if (kind == 3'd5) begin
				target = i + 1 + int'(take_bits(3));
				if (target > program_size - 1)
					target = program_size - 1;
			end else if (kind == 3'd4 && prev_wait) begin
				// backward only over a branch, so loops can exit
				target = i - 1 - int'(take_bits(3));
				if (target < 0)
					target = 0;
			end
			if (target >= 0) begin
				offset = 21'((target - i) * 4);
				program_words[i] = {offset[20], offset[10:1], offset[11], offset[19:12],
					fields[11:7], fetch_pkg::op_jal};
			end else if (kind == 3'd6)
				program_words[i] = {fields[31:7], fetch_pkg::op_branch};
			else if (kind == 3'd7)
				program_words[i] = {fields[31:7], fetch_pkg::op_jalr};
			else if (take_bits(1) == 1)
				program_words[i] = {fields[31:7], 7'b0110011};
			else
				program_words[i] = {fields[31:7], 7'b0010011};
			prev_wait = target < 0 && (kind == 3'd6 || kind == 3'd7);
		end
		repeat (3) @(posedge i_clock);
		i_reset <= 1'b0;
		forever begin
			@(posedge i_clock);
			i_resolve_valid <= 1'b0;
			bus_latency <= 2'(take_bits(2));
			i_stall <= take_bits(2) == 0;
			if (resolves_sent != waits_seen) begin
				if (resolve_delay != 3'd0) begin
					resolve_delay <= resolve_delay - 3'd1;
					// stale tag, must be ignored
					if (take_bits(3) == 0) begin
						i_resolve_valid <= 1'b1;
						i_resolve_tag <= ~o_tag;
						i_pc_next <= take_bits(6) << 2;
					end
				end else begin
					if (take_bits(1) == 1)
						target_pc = o_pc + 32'd4;
					else
						target_pc = take_bits(6) << 2;
					i_resolve_valid <= 1'b1;
					i_resolve_tag <= o_tag;
					i_pc_next <= target_pc;
					resolved_pc <= target_pc;
					resolves_sent <= resolves_sent + 1;
					resolve_delay <= 3'(take_bits(3));
				end
			end
		end
	end

	// outputs sampled mid-cycle
	always @(negedge i_clock) begin
		logic [31:0] want_pc;
		logic [31:0] want_word;
		if (i_reset) begin
			if (cycles > 0) begin
				check_value("o_valid", 32'(o_valid), 32'd0);
				check_value("o_bus_request", 32'(o_bus_request), 32'd0);
			end
		end else if (o_valid) begin
			if (i_stall) begin
				$display("ERROR: delivery at pc 0x%08h while stall is high", o_pc);
				error_count = error_count + 1;
			end
			if (waits_seen != resolves_sent) begin
				$display("ERROR: delivery at pc 0x%08h before the branch was resolved", o_pc);
				error_count = error_count + 1;
			end
			if (deliveries == 0)
				want_pc = fetch_pkg::reset_pc;
			else
				want_pc = expected_next_pc(last_word, last_pc, resolved_pc);
			want_word = program_words[want_pc[7:2]];
			check_value("o_pc", o_pc, want_pc);
			check_value("o_instruction", o_instruction, want_word);
			if (deliveries > 0)
				check_value("o_tag", 32'(o_tag), (32'(last_tag) + 32'd1) & tag_mask);
			if (want_word[6:0] == fetch_pkg::op_branch || want_word[6:0] == fetch_pkg::op_jalr)
				waits_seen = waits_seen + 1;
			last_word = want_word;
			last_pc = want_pc;
			last_tag = o_tag;
			deliveries = deliveries + 1;
		end
		// request and address hold until ready, then the request drops
		if (!i_reset && prev_request) begin
			if (prev_ready) begin
				check_value("o_bus_request", 32'(o_bus_request), 32'd0);
			end else begin
				check_value("o_bus_request", 32'(o_bus_request), 32'd1);
				check_value("o_bus_address", o_bus_address, prev_address);
			end
		end
		prev_request = o_bus_request;
		prev_ready = i_bus_ready;
		prev_address = o_bus_address;
	end

	always @(posedge i_clock) begin
		cycles <= cycles + 1;
		if (deliveries == test_count || cycles == timeout_cycles) begin
			if (deliveries < test_count)
				$display("ERROR: run timed out after %0d cycles", cycles);
			$display("errors: %0d, deliveries: %0d of %0d", error_count, deliveries, test_count);
			if (error_count == 0 && deliveries == test_count)
				$display("test passed");
			else
				$display("test failed");
			$finish;
		end
	end

endmodule

// ==== sim/bus_memory.sv ====
`timescale 1ns/1ps

module bus_memory (
	input logic i_clock,
	input logic i_reset,
	input logic [1:0] i_latency,
	input logic [fetch_pkg::xlen-1:0] i_program [64],
	input logic i_bus_request,
	input logic [fetch_pkg::xlen-1:0] i_bus_address,
	output logic o_bus_ready,
	output logic [fetch_pkg::xlen-1:0] o_bus_rdata
);

	logic [1:0] count;

	// program is 64 words, upper address bits alias
	assign o_bus_rdata = i_program[i_bus_address[7:2]];

	// ready comes 1 to 4 cycles after the request rises
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			count <= '0;
			o_bus_ready <= 1'b0;
		end else if (o_bus_ready || !i_bus_request) begin
			count <= '0;
			o_bus_ready <= 1'b0;
		end else if (count >= i_latency) begin
			o_bus_ready <= 1'b1;
		end else begin
			count <= count + 2'd1;
		end
	end

endmodule

// ==== src/fetch_top.sv ====
`timescale 1ns/1ps

module fetch_top (
	input logic i_clock,
	input logic i_reset,
	input logic i_stall,
	output logic o_bus_request,
	output logic [fetch_pkg::xlen-1:0] o_bus_address,
	input logic i_bus_ready,
	input logic [fetch_pkg::xlen-1:0] i_bus_rdata,
	input logic i_resolve_valid,
	input logic [fetch_pkg::tag_width-1:0] i_resolve_tag,
	input logic [fetch_pkg::xlen-1:0] i_pc_next,
	output logic o_valid,
	output logic [fetch_pkg::tag_width-1:0] o_tag,
	output logic [fetch_pkg::xlen-1:0] o_instruction,
	output logic [fetch_pkg::xlen-1:0] o_pc
);

	// control to cache
	logic req_valid;
	logic [fetch_pkg::xlen-1:0] req_address;
	logic [fetch_pkg::tag_width-1:0] req_tag;

	// cache to control
	logic resp_valid;
	logic [fetch_pkg::tag_width-1:0] resp_tag;
	logic [fetch_pkg::xlen-1:0] resp_data;

	// predecode loop
	logic [fetch_pkg::xlen-1:0] pd_instruction;
	logic [fetch_pkg::xlen-1:0] pd_pc;
	fetch_pkg::instr_class_t instr_class;
	logic [fetch_pkg::xlen-1:0] jal_target;

	fetch_control control_i (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_stall(i_stall),
		.i_resolve_valid(i_resolve_valid),
		.i_resolve_tag(i_resolve_tag),
		.i_pc_next(i_pc_next),
		.o_req_valid(req_valid),
		.o_req_address(req_address),
		.o_req_tag(req_tag),
		.i_resp_valid(resp_valid),
		.i_resp_tag(resp_tag),
		.i_resp_data(resp_data),
		.o_pd_instruction(pd_instruction),
		.o_pd_pc(pd_pc),
		.i_instr_class(instr_class),
		.i_jal_target(jal_target),
		.o_valid(o_valid),
		.o_tag(o_tag),
		.o_instruction(o_instruction),
		.o_pc(o_pc)
	);

	icache icache_i (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_req_valid(req_valid),
		.i_req_address(req_address),
		.i_req_tag(req_tag),
		.o_resp_valid(resp_valid),
		.o_resp_tag(resp_tag),
		.o_resp_data(resp_data),
		.o_bus_request(o_bus_request),
		.o_bus_address(o_bus_address),
		.i_bus_ready(i_bus_ready),
		.i_bus_rdata(i_bus_rdata)
	);

	instr_predecode predecode_i (
		.i_instruction(pd_instruction),
		.i_pc(pd_pc),
		.o_instr_class(instr_class),
		.o_jal_target(jal_target)
	);

endmodule

// ==== fetch/fetch_control.sv ====
`timescale 1ns/1ps

module fetch_control (
	input logic i_clock,
	input logic i_reset,
	input logic i_stall,
	input logic i_resolve_valid,
	input logic [fetch_pkg::tag_width-1:0] i_resolve_tag,
	input logic [fetch_pkg::xlen-1:0] i_pc_next,
	output logic o_req_valid,
	output logic [fetch_pkg::xlen-1:0] o_req_address,
	output logic [fetch_pkg::tag_width-1:0] o_req_tag,
	input logic i_resp_valid,
	input logic [fetch_pkg::tag_width-1:0] i_resp_tag,
	input logic [fetch_pkg::xlen-1:0] i_resp_data,
	output logic [fetch_pkg::xlen-1:0] o_pd_instruction,
	output logic [fetch_pkg::xlen-1:0] o_pd_pc,
	input fetch_pkg::instr_class_t i_instr_class,
	input logic [fetch_pkg::xlen-1:0] i_jal_target,
	output logic o_valid,
	output logic [fetch_pkg::tag_width-1:0] o_tag,
	output logic [fetch_pkg::xlen-1:0] o_instruction,
	output logic [fetch_pkg::xlen-1:0] o_pc
);

	typedef enum logic [1:0] {
		s_issue,
		s_wait_resp,
		s_hold,
		s_wait_resolve
	} state_t;

	state_t state;
	logic [fetch_pkg::xlen-1:0] pc;
	logic [fetch_pkg::xlen-1:0] next_pc;
	logic [fetch_pkg::xlen-1:0] hold_data;
	logic outstanding;
	logic valid_pending;
	logic resp_match;
	logic deliver;
	logic resolve_accept;
	logic issue;

	// pc always holds the address of the current request
	assign o_req_address = pc;
	assign o_pd_pc = pc;
	assign o_pd_instruction = (state == s_hold) ? hold_data : i_resp_data;

	// stale tags are dropped here
	assign resp_match = i_resp_valid && outstanding && (i_resp_tag == o_req_tag);
	assign deliver = !i_stall && ((state == s_wait_resp && resp_match) || state == s_hold);
	assign resolve_accept = (state == s_wait_resolve) && i_resolve_valid &&
		(i_resolve_tag == o_tag);

	// a delivery made just before stall rises waits until stall drops
	assign o_valid = valid_pending && !i_stall;

	always_comb begin
		issue = 1'b0;
		next_pc = pc;
		if (state == s_issue) begin
			issue = !i_stall;
		end else if (deliver) begin
			case (i_instr_class)
				fetch_pkg::class_seq: begin
					issue = 1'b1;
					next_pc = pc + 32'd4;
				end
				fetch_pkg::class_jal: begin
					issue = 1'b1;
					next_pc = i_jal_target;
				end
				default: issue = 1'b0;
			endcase
		end else if (resolve_accept) begin
			issue = !i_stall;
			next_pc = i_pc_next;
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= s_issue;
			pc <= fetch_pkg::reset_pc;
			o_req_valid <= 1'b0;
			o_req_tag <= '0;
			outstanding <= 1'b0;
			valid_pending <= 1'b0;
		end else begin
			o_req_valid <= 1'b0;
			if (o_req_valid)
				outstanding <= 1'b1;
			else if (resp_match)
				outstanding <= 1'b0;
			if (deliver)
				valid_pending <= 1'b1;
			else if (!i_stall)
				valid_pending <= 1'b0;
			if (issue) begin
				o_req_valid <= 1'b1;
				o_req_tag <= o_req_tag + 1'b1;
				pc <= next_pc;
				state <= s_wait_resp;
			end else if (resolve_accept) begin
				// resolved while stalled, issue once stall drops
				pc <= i_pc_next;
				state <= s_issue;
			end else if (deliver) begin
				state <= s_wait_resolve;
			end else if (state == s_wait_resp && resp_match) begin
				state <= s_hold;
			end
		end
	end

	// payload registers
	always_ff @(posedge i_clock) begin
		if (state == s_wait_resp && resp_match && i_stall)
			hold_data <= i_resp_data;
		if (deliver) begin
			o_tag <= o_req_tag;
			o_instruction <= o_pd_instruction;
			o_pc <= pc;
		end
	end

	// no delivery is shown twice
	assert property (@(posedge i_clock) disable iff (i_reset)
		o_valid |=> !o_valid || (o_tag != $past(o_tag)));
	assert property (@(posedge i_clock) disable iff (i_reset) o_req_valid |-> !outstanding);

endmodule

// ==== fetch/icache.sv ====
`timescale 1ns/1ps

module icache (
	input logic i_clock,
	input logic i_reset,
	input logic i_req_valid,
	input logic [fetch_pkg::xlen-1:0] i_req_address,
	input logic [fetch_pkg::tag_width-1:0] i_req_tag,
	output logic o_resp_valid,
	output logic [fetch_pkg::tag_width-1:0] o_resp_tag,
	output logic [fetch_pkg::xlen-1:0] o_resp_data,
	output logic o_bus_request,
	output logic [fetch_pkg::xlen-1:0] o_bus_address,
	input logic i_bus_ready,
	input logic [fetch_pkg::xlen-1:0] i_bus_rdata
);

	logic [fetch_pkg::icache_lines-1:0] line_valid;
	logic [fetch_pkg::xlen-1:fetch_pkg::icache_index_width+2] line_tag
		[fetch_pkg::icache_lines];
	logic [fetch_pkg::xlen-1:0] line_data [fetch_pkg::icache_lines];

	logic [fetch_pkg::icache_index_width-1:0] req_index;
	logic [fetch_pkg::icache_index_width-1:0] fill_index;
	logic hit;
	logic fill_done;
	logic accept;

	// word address bits select the line
	assign req_index = i_req_address[fetch_pkg::icache_index_width+1:2];
	assign fill_index = o_bus_address[fetch_pkg::icache_index_width+1:2];

	assign hit = line_valid[req_index] &&
		(line_tag[req_index] == i_req_address[fetch_pkg::xlen-1:fetch_pkg::icache_index_width+2]);

	assign fill_done = o_bus_request && i_bus_ready;
	// no new lookup while a fill is running
	assign accept = i_req_valid && !o_bus_request;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			line_valid <= '0;
			o_resp_valid <= 1'b0;
			o_bus_request <= 1'b0;
		end else begin
			o_resp_valid <= 1'b0;
			if (fill_done) begin
				o_bus_request <= 1'b0;
				line_valid[fill_index] <= 1'b1;
				o_resp_valid <= 1'b1;
			end else if (accept) begin
				if (hit)
					o_resp_valid <= 1'b1;
				else
					o_bus_request <= 1'b1;
			end
		end
	end

	// tag echo, data and fill address
	always_ff @(posedge i_clock) begin
		if (accept) begin
			o_resp_tag <= i_req_tag;
			o_resp_data <= line_data[req_index];
			o_bus_address <= {i_req_address[fetch_pkg::xlen-1:2], 2'b00};
		end
		if (fill_done) begin
			line_tag[fill_index] <=
				o_bus_address[fetch_pkg::xlen-1:fetch_pkg::icache_index_width+2];
			line_data[fill_index] <= i_bus_rdata;
			o_resp_data <= i_bus_rdata;
		end
	end

	// bus request and address held until ready
	assert property (@(posedge i_clock) disable iff (i_reset)
		o_bus_request && !i_bus_ready |=> o_bus_request && $stable(o_bus_address));

	// a new request only once the previous one has answered
	assert property (@(posedge i_clock) disable iff (i_reset)
		i_req_valid |-> !o_bus_request && !o_resp_valid);

endmodule

// ==== src/instr_predecode.sv ====
`timescale 1ns/1ps

module instr_predecode (
	input logic [fetch_pkg::xlen-1:0] i_instruction,
	input logic [fetch_pkg::xlen-1:0] i_pc,
	output fetch_pkg::instr_class_t o_instr_class,
	output logic [fetch_pkg::xlen-1:0] o_jal_target
);

	logic [6:0] opcode;
	logic [fetch_pkg::xlen-1:0] j_imm;

	assign opcode = i_instruction[6:0];

	// J-type immediate, bit 0 always zero
	assign j_imm = {
		{(fetch_pkg::xlen-20){i_instruction[31]}},
		i_instruction[19:12],
		i_instruction[20],
		i_instruction[30:21],
		1'b0
	};

	assign o_jal_target = i_pc + j_imm;

	always_comb begin
		case (opcode)
			fetch_pkg::op_jal:
				o_instr_class = fetch_pkg::class_jal;
			// target only known after execute
			fetch_pkg::op_branch,
			fetch_pkg::op_jalr:
				o_instr_class = fetch_pkg::class_wait;
			default:
				o_instr_class = fetch_pkg::class_seq;
		endcase
	end

endmodule

// ==== common/fetch_pkg.sv ====
package fetch_pkg;

	// datapath and address width
	localparam int xlen = 32;

	// fetch tag width, tags wrap
	localparam int tag_width = 4;

	// direct-mapped cache, one word per line
	localparam int icache_lines = 16;
	localparam int icache_index_width = 4;

	// first fetch address after reset
	localparam logic [xlen-1:0] reset_pc = '0;

	// RV32I major opcodes that change control flow
	localparam logic [6:0] op_branch = 7'b1100011;
	localparam logic [6:0] op_jal = 7'b1101111;
	localparam logic [6:0] op_jalr = 7'b1100111;

	// how the fetch unit continues after an instruction
	//   class_seq  falls through to pc + 4
	//   class_jal  static redirect to the jal target
	//   class_wait needs the resolved pc from execute
	typedef enum logic [1:0] {
		class_seq = 2'd0,
		class_jal = 2'd1,
		class_wait = 2'd2
	} instr_class_t;

endpackage
